/* Makefile */
TOP := cpu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

/* dv/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_tb;

	import cpu_isa_pkg::*;

	localparam int W = `CPU_DATA_WIDTH;
	localparam int RB = $clog2(`CPU_REG_COUNT);
	localparam int IA = $clog2(`CPU_IMEM_DEPTH);
	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 2;
	localparam int RESET_CYCLES = 16;
	localparam int MARGIN_CYCLES = 40;
	localparam int POST_HALT_CYCLES = 8;

	logic clk;
	logic reset;
	logic imem_we;
	logic [IA-1:0] imem_addr;
	logic [W-1:0] imem_wdata;
	logic hlt;
	logic [W-1:0] pc_out;
	logic retire_valid;
	logic [RB-1:0] retire_reg;
	logic [W-1:0] retire_data;

	// Program image and expected register writes, in retirement order
	logic [W-1:0] prog_words [$];
	logic [RB-1:0] exp_reg [$];
	logic [W-1:0] exp_val [$];
	logic [W-1:0] halt_pc;
	int next_idx;
	int value_errs;
	int other_errs;
	int watchdog_cycles;

	cpu cpu_inst (
		.clk(clk),
		.reset(reset),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_wdata(imem_wdata),
		.hlt(hlt),
		.pc_out(pc_out),
		.retire_valid(retire_valid),
		.retire_reg(retire_reg),
		.retire_data(retire_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ------------------------------------------------------------------
	// Instruction encoders
	// ------------------------------------------------------------------
	// opcode, [11:8], [7:4], [3:0]
	function automatic logic [W-1:0] fields(input opcode_t op, input logic [3:0] f2,
		input logic [3:0] f1, input logic [3:0] f0);
		return {op, f2, f1, f0};
	endfunction

	// LHB and LLB
	function automatic logic [W-1:0] byte_imm(input opcode_t op, input logic [3:0] rd,
		input logic [7:0] imm8);
		return {op, rd, imm8};
	endfunction

	// Target is PC+2 plus off*2
	function automatic logic [W-1:0] rel_branch(input cond_t cc, input logic [8:0] off);
		return {OP_B, cc, off};
	endfunction

	function automatic logic [W-1:0] reg_branch(input cond_t cc, input logic [3:0] rs);
		return {OP_BR, cc, 1'b0, rs, 4'h0};
	endfunction

	task automatic expect_write(input logic [RB-1:0] r, input logic [W-1:0] v);
		exp_reg.push_back(r);
		exp_val.push_back(v);
	endtask

	// ------------------------------------------------------------------
	// Program and expected retirements
	// ------------------------------------------------------------------
	task automatic build_tables();
		// ALU chain, each op feeds the next
		prog_words.push_back(byte_imm(OP_LLB, 4'd1, 8'h34));
		prog_words.push_back(byte_imm(OP_LHB, 4'd1, 8'h12));
		prog_words.push_back(byte_imm(OP_LLB, 4'd2, 8'hF0));
		prog_words.push_back(fields(OP_ADD, 4'd3, 4'd1, 4'd2));
		prog_words.push_back(fields(OP_SUB, 4'd4, 4'd3, 4'd1));
		prog_words.push_back(fields(OP_XOR, 4'd5, 4'd4, 4'd1));
		prog_words.push_back(fields(OP_AND, 4'd6, 4'd5, 4'd3));
		prog_words.push_back(fields(OP_OR, 4'd7, 4'd6, 4'd2));
		prog_words.push_back(fields(OP_SLL, 4'd8, 4'd7, 4'd3));
		prog_words.push_back(fields(OP_SRA, 4'd9, 4'd8, 4'd4));
		prog_words.push_back(fields(OP_ROR, 4'd10, 4'd9, 4'd8));
		// Store then load at r11 + 4, consumer right behind the load
		prog_words.push_back(byte_imm(OP_LLB, 4'd11, 8'h20));
		prog_words.push_back(fields(OP_SW, 4'd10, 4'd11, 4'd2));
		prog_words.push_back(fields(OP_LW, 4'd12, 4'd11, 4'd2));
		prog_words.push_back(fields(OP_ADD, 4'd13, 4'd12, 4'd1));
		// Z set, EQ taken over two r15 writes
		prog_words.push_back(fields(OP_SUB, 4'd14, 4'd4, 4'd2));
		prog_words.push_back(rel_branch(COND_EQ, 9'd2));
		prog_words.push_back(byte_imm(OP_LLB, 4'd15, 8'hAA));
		prog_words.push_back(byte_imm(OP_LLB, 4'd15, 8'hBB));
		// NE not taken, shadow retires
		prog_words.push_back(rel_branch(COND_NE, 9'd2));
		prog_words.push_back(byte_imm(OP_LLB, 4'd15, 8'h11));
		prog_words.push_back(byte_imm(OP_LHB, 4'd15, 8'h22));
		// Z clear, NE taken
		prog_words.push_back(fields(OP_SUB, 4'd14, 4'd1, 4'd2));
		prog_words.push_back(rel_branch(COND_NE, 9'd2));
		prog_words.push_back(byte_imm(OP_LLB, 4'd13, 8'h55));
		prog_words.push_back(byte_imm(OP_LLB, 4'd13, 8'h66));
		// Return address 0x3C built from PCS, call to 0x42
		prog_words.push_back(fields(OP_PCS, 4'd12, 4'd0, 4'd0));
		prog_words.push_back(byte_imm(OP_LLB, 4'd11, 8'h06));
		prog_words.push_back(fields(OP_ADD, 4'd12, 4'd12, 4'd11));
		prog_words.push_back(rel_branch(COND_UNCOND, 9'd3));
		// Return point, then halt
		prog_words.push_back(byte_imm(OP_LLB, 4'd10, 8'h01));
		halt_pc = W'(2 * prog_words.size() + 2);
		prog_words.push_back(fields(OP_HLT, 4'd0, 4'd0, 4'd0));
		// Never fetched once halted
		prog_words.push_back(byte_imm(OP_LLB, 4'd10, 8'hEE));
		// Subroutine body and return
		prog_words.push_back(byte_imm(OP_LHB, 4'd9, 8'h5A));
		prog_words.push_back(reg_branch(COND_UNCOND, 4'd12));
		prog_words.push_back(byte_imm(OP_LLB, 4'd15, 8'hC1));
		prog_words.push_back(byte_imm(OP_LLB, 4'd15, 8'hC2));

		expect_write(4'd1, 16'h0034);
		expect_write(4'd1, 16'h1234);
		expect_write(4'd2, 16'h00F0);
		expect_write(4'd3, 16'h1324);
		expect_write(4'd4, 16'h00F0);
		expect_write(4'd5, 16'h12C4);
		expect_write(4'd6, 16'h1204);
		expect_write(4'd7, 16'h12F4);
		expect_write(4'd8, 16'h97A0);
		expect_write(4'd9, 16'hF97A);
		expect_write(4'd10, 16'h7AF9);
		expect_write(4'd11, 16'h0020);
		expect_write(4'd12, 16'h7AF9);
		// 0x7AF9 + 0x1234, signed overflow
		expect_write(4'd13, 16'h8D2D);
		expect_write(4'd14, 16'h0000);
		expect_write(4'd15, 16'h0011);
		expect_write(4'd15, 16'h2211);
		expect_write(4'd14, 16'h1144);
		expect_write(4'd12, 16'h0036);
		expect_write(4'd11, 16'h0006);
		expect_write(4'd12, 16'h003C);
		expect_write(4'd9, 16'h5A7A);
		// After the BR return
		expect_write(4'd10, 16'h7A01);
	endtask

	// ------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------
	task automatic check_value(input string name, input logic [W-1:0] expected,
		input logic [W-1:0] actual);
		assert (actual === expected) else begin
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
			value_errs++;
		end
	endtask

	task automatic check_reset_state();
		check_value("hlt", '0, W'(hlt));
		check_value("retire_valid", '0, W'(retire_valid));
		check_value("pc_out", '0, pc_out);
	endtask

	// Next table entry against the retirement port
	task automatic check_retirement();
		assert (next_idx < exp_reg.size()) else begin
			$display("Retirement of r%0d = %h at %0t with no expected write left",
				retire_reg, retire_data, $time);
			other_errs++;
		end
		if (next_idx < exp_reg.size()) begin
			check_value("retire_reg", W'(exp_reg[next_idx]), W'(retire_reg));
			check_value("retire_data", exp_val[next_idx], retire_data);
			next_idx++;
		end
	endtask

	// ------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------
	initial begin
		clk = 1'b0;
		reset = 1'b1;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		next_idx = 0;
		value_errs = 0;
		other_errs = 0;
		build_tables();
		watchdog_cycles = prog_words.size() * 4 + RESET_CYCLES + MARGIN_CYCLES;

		// Program load inside the reset window
		for (int i = 0; i < prog_words.size(); i++) begin
			@(posedge clk);
			#DRIVE_DELAY;
			imem_we = 1'b1;
			imem_addr = IA'(i);
			imem_wdata = prog_words[i];
		end
		@(posedge clk);
		#DRIVE_DELAY;
		imem_we = 1'b0;

		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_reset_state();
		end
		@(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;

		// Every retirement until hlt, sampled mid-cycle
		do begin
			@(negedge clk);
			if (retire_valid)
				check_retirement();
		end while (!hlt);

		check_value("pc_out", halt_pc, pc_out);
		repeat (POST_HALT_CYCLES) begin
			@(negedge clk);
			assert (!retire_valid) else begin
				$display("Register r%0d written at %0t after the halt", retire_reg, $time);
				other_errs++;
			end
			check_value("hlt", W'(1), W'(hlt));
			check_value("pc_out", halt_pc, pc_out);
		end

		assert (next_idx == exp_reg.size()) else begin
			$display("Only %0d of %0d expected register writes retired",
				next_idx, exp_reg.size());
			other_errs++;
		end

		$display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Budget follows the program length
	initial begin
		#1;
		#(watchdog_cycles * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles and the CPU never halted",
			watchdog_cycles);
		$display("Errors: %0d value mismatches, %0d other failures",
			value_errs, other_errs + 1);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* files.f */
+incdir+include
source/cpu_isa_pkg.sv
source/cpu_pipe_pkg.sv
source/cpu_fetch.sv
source/cpu_decode.sv
source/cpu_execute.sv
source/cpu_result.sv
source/cpu.sv
dv/cpu_tb.sv

/* include/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath and instruction word width
`define CPU_DATA_WIDTH 16

// Architectural registers
`define CPU_REG_COUNT 16

// Instruction memory size in 16-bit words
`define CPU_IMEM_DEPTH 256

// Data memory size in 16-bit words
`define CPU_DMEM_DEPTH 256

`endif

/* source/cpu.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu (
	input  logic clk,
	input  logic reset,
	input  logic imem_we,
	input  logic [$clog2(`CPU_IMEM_DEPTH)-1:0] imem_addr,
	input  logic [`CPU_DATA_WIDTH-1:0] imem_wdata,
	output logic hlt,
	output logic [`CPU_DATA_WIDTH-1:0] pc_out,
	output logic retire_valid,
	output logic [$clog2(`CPU_REG_COUNT)-1:0] retire_reg,
	output logic [`CPU_DATA_WIDTH-1:0] retire_data
);

	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	localparam int W = `CPU_DATA_WIDTH;
	localparam int RB = $clog2(`CPU_REG_COUNT);

	// ------------------------------------------------------------------
	// Stage to stage wiring, matched by name
	// ------------------------------------------------------------------
	// Fetch to decode
	logic [W-1:0] fd_instr;
	logic [W-1:0] fd_pc_next;
	logic fd_valid;

	// Holds and redirect
	logic stall;
	logic halt_req;
	logic branch_taken;
	logic [W-1:0] branch_target;

	// Decode to execute
	opcode_t de_op;
	logic [W-1:0] de_a;
	logic [W-1:0] de_b;
	logic de_store;
	logic [RB-1:0] de_rs;
	logic [RB-1:0] de_rt;
	logic [RB-1:0] de_dest;
	logic [W-1:0] de_imm;
	logic [W-1:0] de_pc_next;
	logic de_wen;
	logic de_valid;

	// Load-use check
	logic ex_load;
	logic [RB-1:0] ex_dest;

	// Execute to result
	logic [W-1:0] ex_value;
	logic [W-1:0] ex_store_data;
	logic [W-1:0] ex_addr;
	logic [RB-1:0] ex_wreg;
	logic ex_wen;
	logic ex_store;
	logic ex_halt;
	logic ex_valid;
	res_src_t ex_src;

	// Result stage forwarding
	logic [W-1:0] mem_fwd_data;
	logic [RB-1:0] mem_dest;
	logic mem_wen;

	cpu_fetch fetch_inst (.*);

	cpu_decode decode_inst (.*);

	cpu_execute execute_inst (.*);

	// Also drives writeback forwarding and the register file
	cpu_result result_inst (.*);

endmodule

/* source/cpu_decode.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_decode (
	input  logic clk,
	input  logic reset,
	input  logic [`CPU_DATA_WIDTH-1:0] fd_instr,
	input  logic [`CPU_DATA_WIDTH-1:0] fd_pc_next,
	input  logic fd_valid,
	input  logic branch_taken,
	input  logic ex_load,
	input  logic [$clog2(`CPU_REG_COUNT)-1:0] ex_dest,
	input  logic retire_valid,
	input  logic [$clog2(`CPU_REG_COUNT)-1:0] retire_reg,
	input  logic [`CPU_DATA_WIDTH-1:0] retire_data,
	output logic stall,
	output logic halt_req,
	output cpu_isa_pkg::opcode_t de_op,
	output logic [`CPU_DATA_WIDTH-1:0] de_a,
	output logic [`CPU_DATA_WIDTH-1:0] de_b,
	output logic de_store,
	output logic [$clog2(`CPU_REG_COUNT)-1:0] de_rs,
	output logic [$clog2(`CPU_REG_COUNT)-1:0] de_rt,
	output logic [$clog2(`CPU_REG_COUNT)-1:0] de_dest,
	output logic [`CPU_DATA_WIDTH-1:0] de_imm,
	output logic [`CPU_DATA_WIDTH-1:0] de_pc_next,
	output logic de_wen,
	output logic de_valid
);

	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	localparam int W = `CPU_DATA_WIDTH;
	localparam int RB = $clog2(`CPU_REG_COUNT);

	logic [W-1:0] regs [`CPU_REG_COUNT];
	opcode_t op;
	logic [RB-1:0] rs_sel;
	logic [RB-1:0] rt_sel;
	logic use_a;
	logic use_b;
	logic wen;
	logic issue;
	logic [W-1:0] imm;
	logic [W-1:0] rd_a;
	logic [W-1:0] rd_b;
	run_state_t state;

	assign op = opcode_t'(fd_instr[15:12]);

	// ------------------------------------------------------------------
	// Control decode
	// ------------------------------------------------------------------
	// Default is a plain register-register op with shift amount in imm
	always_comb begin
		rs_sel = fd_instr[7:4];
		rt_sel = fd_instr[3:0];
		use_a = 1'b1;
		use_b = 1'b0;
		wen = 1'b1;
		imm = {12'h000, fd_instr[3:0]};
		case (op)
			OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_OR: use_b = 1'b1;
			OP_LW: imm = {{11{fd_instr[3]}}, fd_instr[3:0], 1'b0};
			OP_SW: begin
				// Store data comes from the rd field
				rt_sel = fd_instr[11:8];
				use_b = 1'b1;
				wen = 1'b0;
				imm = {{11{fd_instr[3]}}, fd_instr[3:0], 1'b0};
			end
			OP_LHB, OP_LLB: begin
				// Half loads keep the other byte of rd
				rs_sel = fd_instr[11:8];
				imm = {8'h00, fd_instr[7:0]};
			end
			OP_B: begin
				use_a = 1'b0;
				wen = 1'b0;
				imm = {{6{fd_instr[8]}}, fd_instr[8:0], 1'b0};
			end
			OP_BR: wen = 1'b0;
			OP_PCS: use_a = 1'b0;
			OP_HLT: begin
				use_a = 1'b0;
				wen = 1'b0;
			end
			default: use_b = 1'b0;
		endcase
	end

	// Write-first bypass from writeback
	assign rd_a = (retire_valid && retire_reg == rs_sel) ? retire_data : regs[rs_sel];
	assign rd_b = (retire_valid && retire_reg == rt_sel) ? retire_data : regs[rt_sel];

	// Load in execute feeding this instruction
	assign stall = fd_valid && ex_load
		&& ((use_a && ex_dest == rs_sel) || (use_b && ex_dest == rt_sel));

	// Freeze fetch from the HLT on, unless a branch flushes it
	assign halt_req = (fd_valid && op == OP_HLT && !branch_taken) || state == HALTING;
	assign issue = fd_valid && !stall && !branch_taken && state == RUN;

	// Register file
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (retire_valid) begin
			regs[retire_reg] <= retire_data;
		end
	end

	// Nothing issues after the HLT
	always_ff @(posedge clk) begin
		if (reset)
			state <= RUN;
		else if (issue && op == OP_HLT)
			state <= HALTING;
	end

	// ------------------------------------------------------------------
	// Decode/execute register
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			de_valid <= 1'b0;
			de_wen <= 1'b0;
			de_store <= 1'b0;
		end else begin
			// Stall, flush and halt all leave a bubble
			de_valid <= issue;
			de_wen <= issue && wen;
			de_store <= issue && op == OP_SW;
		end
	end

	always_ff @(posedge clk) begin
		de_op <= op;
		de_a <= rd_a;
		de_b <= rd_b;
		de_rs <= rs_sel;
		de_rt <= rt_sel;
		// Raw [11:8]; branches take their condition from here
		de_dest <= fd_instr[11:8];
		de_imm <= imm;
		de_pc_next <= fd_pc_next;
	end

endmodule

/* source/cpu_execute.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_execute (
	input  logic clk,
	input  logic reset,
	input  cpu_isa_pkg::opcode_t de_op,
	input  logic [`CPU_DATA_WIDTH-1:0] de_a,
	input  logic [`CPU_DATA_WIDTH-1:0] de_b,
	input  logic de_store,
	input  logic [$clog2(`CPU_REG_COUNT)-1:0] de_rs,
	input  logic [$clog2(`CPU_REG_COUNT)-1:0] de_rt,
	input  logic [$clog2(`CPU_REG_COUNT)-1:0] de_dest,
	input  logic [`CPU_DATA_WIDTH-1:0] de_imm,
	input  logic [`CPU_DATA_WIDTH-1:0] de_pc_next,
	input  logic de_wen,
	input  logic de_valid,
	input  logic [`CPU_DATA_WIDTH-1:0] mem_fwd_data,
	input  logic [$clog2(`CPU_REG_COUNT)-1:0] mem_dest,
	input  logic mem_wen,
	input  logic retire_valid,
	input  logic [$clog2(`CPU_REG_COUNT)-1:0] retire_reg,
	input  logic [`CPU_DATA_WIDTH-1:0] retire_data,
	output logic branch_taken,
	output logic [`CPU_DATA_WIDTH-1:0] branch_target,
	output logic ex_load,
	output logic [$clog2(`CPU_REG_COUNT)-1:0] ex_dest,
	output logic [`CPU_DATA_WIDTH-1:0] ex_value,
	output logic [`CPU_DATA_WIDTH-1:0] ex_store_data,
	output logic [`CPU_DATA_WIDTH-1:0] ex_addr,
	output logic [$clog2(`CPU_REG_COUNT)-1:0] ex_wreg,
	output logic ex_wen,
	output logic ex_store,
	output logic ex_halt,
	output logic ex_valid,
	output cpu_pipe_pkg::res_src_t ex_src
);

	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	localparam int W = `CPU_DATA_WIDTH;
	localparam int RB = $clog2(`CPU_REG_COUNT);

	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;
	logic [W-1:0] op_a;
	logic [W-1:0] op_b;
	logic [W-1:0] alu_out;
	logic [W-1:0] half;
	logic [W-1:0] value;
	logic [2:0] flags;
	logic ovf;
	logic is_branch;
	res_src_t src;

	// Result stage is younger and wins
	function automatic fwd_sel_t pick_fwd(input logic [RB-1:0] num);
		if (mem_wen && mem_dest == num)
			return FWD_RESULT;
		if (retire_valid && retire_reg == num)
			return FWD_WRITEBACK;
		return FWD_NONE;
	endfunction

	function automatic logic cond_met(input cond_t cc, input logic [2:0] f);
		case (cc)
			COND_NE: return !f[FLAG_Z];
			COND_EQ: return f[FLAG_Z];
			COND_GT: return !f[FLAG_Z] && !f[FLAG_N];
			COND_LT: return f[FLAG_N];
			COND_GE: return f[FLAG_Z] || !f[FLAG_N];
			COND_LE: return f[FLAG_Z] || f[FLAG_N];
			COND_OV: return f[FLAG_V];
			default: return 1'b1;
		endcase
	endfunction

	// ------------------------------------------------------------------
	// Operand forwarding
	// ------------------------------------------------------------------
	assign fwd_a = pick_fwd(de_rs);
	assign fwd_b = pick_fwd(de_rt);
	assign op_a = (fwd_a == FWD_RESULT) ? mem_fwd_data :
		(fwd_a == FWD_WRITEBACK) ? retire_data : de_a;
	assign op_b = (fwd_b == FWD_RESULT) ? mem_fwd_data :
		(fwd_b == FWD_WRITEBACK) ? retire_data : de_b;

	// ALU with the shift amount in imm[3:0]
	always_comb begin
		logic [2*W-1:0] rot;
		rot = {op_a, op_a} >> de_imm[3:0];
		ovf = 1'b0;
		case (de_op)
			OP_ADD: begin
				alu_out = op_a + op_b;
				ovf = (op_a[W-1] == op_b[W-1]) && (alu_out[W-1] != op_a[W-1]);
			end
			OP_SUB: begin
				alu_out = op_a - op_b;
				ovf = (op_a[W-1] != op_b[W-1]) && (alu_out[W-1] != op_a[W-1]);
			end
			OP_XOR: alu_out = op_a ^ op_b;
			OP_AND: alu_out = op_a & op_b;
			OP_OR: alu_out = op_a | op_b;
			OP_SLL: alu_out = op_a << de_imm[3:0];
			OP_SRA: alu_out = $signed(op_a) >>> de_imm[3:0];
			OP_ROR: alu_out = rot[W-1:0];
			default: alu_out = op_a;
		endcase
	end

	// LHB replaces the high byte, LLB the low byte
	assign half = (de_op == OP_LHB) ? {de_imm[7:0], op_a[7:0]} : {op_a[15:8], de_imm[7:0]};

	always_comb begin
		case (de_op)
			OP_LW: src = RES_LOAD;
			OP_LHB, OP_LLB: src = RES_HALF;
			OP_PCS: src = RES_PCS;
			default: src = RES_ALU;
		endcase
	end

	assign value = (src == RES_HALF) ? half : (src == RES_PCS) ? de_pc_next : alu_out;

	// Arithmetic sets all three flags while logic and shifts set only Z
	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= '0;
		end else if (de_valid) begin
			case (de_op)
				OP_ADD, OP_SUB: begin
					flags[FLAG_Z] <= (alu_out == '0);
					flags[FLAG_V] <= ovf;
					flags[FLAG_N] <= alu_out[W-1];
				end
				OP_XOR, OP_AND, OP_OR, OP_SLL, OP_SRA, OP_ROR:
					flags[FLAG_Z] <= (alu_out == '0);
				default: flags <= flags;
			endcase
		end
	end

	// ------------------------------------------------------------------
	// Branch decision
	// ------------------------------------------------------------------
	// Condition code rides in de_dest[3:1]
	assign is_branch = de_valid && (de_op == OP_B || de_op == OP_BR);
	assign branch_taken = is_branch && cond_met(cond_t'(de_dest[3:1]), flags);
	assign branch_target = (de_op == OP_BR) ? op_a : de_pc_next + de_imm;

	// Load-use check in decode
	assign ex_load = de_valid && de_op == OP_LW;
	assign ex_dest = de_dest;

	// Execute/result register
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_valid <= 1'b0;
			ex_wen <= 1'b0;
			ex_store <= 1'b0;
			ex_halt <= 1'b0;
		end else begin
			ex_valid <= de_valid;
			ex_wen <= de_wen;
			ex_store <= de_store;
			ex_halt <= de_valid && de_op == OP_HLT;
		end
	end

	always_ff @(posedge clk) begin
		ex_value <= value;
		ex_store_data <= op_b;
		ex_addr <= op_a + de_imm;
		ex_wreg <= de_dest;
		ex_src <= src;
	end

	// Load-use bubble keeps a load in the result stage away from operand A
	a_fwd_no_load: assert property (@(posedge clk) disable iff (reset)
		de_valid && fwd_a == FWD_RESULT && !(de_op inside {OP_B, OP_PCS, OP_HLT})
		|-> ex_src != RES_LOAD);

	// Shadow is empty one cycle after a redirect
	a_branch_flush: assert property (@(posedge clk) disable iff (reset)
		branch_taken |=> !de_valid);

endmodule

/* source/cpu_fetch.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_fetch (
	input  logic clk,
	input  logic reset,
	input  logic imem_we,
	input  logic [$clog2(`CPU_IMEM_DEPTH)-1:0] imem_addr,
	input  logic [`CPU_DATA_WIDTH-1:0] imem_wdata,
	input  logic stall,
	input  logic halt_req,
	input  logic branch_taken,
	input  logic [`CPU_DATA_WIDTH-1:0] branch_target,
	output logic [`CPU_DATA_WIDTH-1:0] pc_out,
	output logic [`CPU_DATA_WIDTH-1:0] fd_instr,
	output logic [`CPU_DATA_WIDTH-1:0] fd_pc_next,
	output logic fd_valid
);

	localparam int W = `CPU_DATA_WIDTH;
	localparam int IA = $clog2(`CPU_IMEM_DEPTH);

	logic [W-1:0] imem [`CPU_IMEM_DEPTH];
	logic [W-1:0] pc;
	logic [W-1:0] pc_plus2;
	logic hold;

	assign pc_plus2 = pc + W'(2);
	assign hold = stall | halt_req;
	assign pc_out = pc;

	// Program load, only while reset is held
	always_ff @(posedge clk) begin
		if (imem_we)
			imem[imem_addr] <= imem_wdata;
	end

	// ------------------------------------------------------------------
	// PC and fetch/decode valid
	// ------------------------------------------------------------------
	// Branch redirect wins over a hold
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			fd_valid <= 1'b0;
		end else if (branch_taken) begin
			pc <= branch_target;
			fd_valid <= 1'b0;
		end else if (!hold) begin
			pc <= pc_plus2;
			fd_valid <= 1'b1;
		end
	end

	// Word addressed, byte PC
	always_ff @(posedge clk) begin
		if (!hold) begin
			fd_instr <= imem[pc[IA:1]];
			fd_pc_next <= pc_plus2;
		end
	end

	// Load port belongs to the reset window
	a_load_in_reset: assert property (@(posedge clk) imem_we |-> reset);

endmodule

/* source/cpu_isa_pkg.sv */
package cpu_isa_pkg;

	// Major opcode, instruction bits [15:12]
	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_XOR = 4'h2,
		OP_AND = 4'h3,
		OP_SLL = 4'h4,
		OP_SRA = 4'h5,
		OP_ROR = 4'h6,
		OP_OR  = 4'h7,
		OP_LW  = 4'h8,
		OP_SW  = 4'h9,
		OP_LHB = 4'hA,
		OP_LLB = 4'hB,
		OP_B   = 4'hC,
		OP_BR  = 4'hD,
		OP_PCS = 4'hE,
		OP_HLT = 4'hF
	} opcode_t;

	// Branch condition, instruction bits [11:9]
	typedef enum logic [2:0] {
		COND_NE     = 3'd0,
		COND_EQ     = 3'd1,
		COND_GT     = 3'd2,
		COND_LT     = 3'd3,
		COND_GE     = 3'd4,
		COND_LE     = 3'd5,
		COND_OV     = 3'd6,
		COND_UNCOND = 3'd7
	} cond_t;

	// Bit positions in the 3-bit flag register
	localparam int FLAG_N = 0;
	localparam int FLAG_V = 1;
	localparam int FLAG_Z = 2;

endpackage

/* source/cpu_pipe_pkg.sv */
package cpu_pipe_pkg;

	// Operand source in execute
	typedef enum logic [1:0] {
		FWD_NONE,
		FWD_RESULT,
		FWD_WRITEBACK
	} fwd_sel_t;

	// Which value the result stage hands to writeback
	typedef enum logic [1:0] {
		RES_ALU,
		RES_HALF,
		RES_PCS,
		RES_LOAD
	} res_src_t;

	// Halt progress
	typedef enum logic [1:0] {
		RUN,
		HALTING,
		HALTED
	} run_state_t;

endpackage

/* source/cpu_result.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_result (
	input  logic clk,
	input  logic reset,
	input  logic [`CPU_DATA_WIDTH-1:0] ex_value,
	input  logic [`CPU_DATA_WIDTH-1:0] ex_store_data,
	input  logic [`CPU_DATA_WIDTH-1:0] ex_addr,
	input  logic [$clog2(`CPU_REG_COUNT)-1:0] ex_wreg,
	input  logic ex_wen,
	input  logic ex_store,
	input  logic ex_halt,
	input  logic ex_valid,
	input  cpu_pipe_pkg::res_src_t ex_src,
	output logic [`CPU_DATA_WIDTH-1:0] mem_fwd_data,
	output logic [$clog2(`CPU_REG_COUNT)-1:0] mem_dest,
	output logic mem_wen,
	output logic retire_valid,
	output logic [$clog2(`CPU_REG_COUNT)-1:0] retire_reg,
	output logic [`CPU_DATA_WIDTH-1:0] retire_data,
	output logic hlt
);

	import cpu_pipe_pkg::*;

	localparam int W = `CPU_DATA_WIDTH;
	localparam int DA = $clog2(`CPU_DMEM_DEPTH);

	logic [W-1:0] dmem [`CPU_DMEM_DEPTH];
	logic load;
	logic store;
	run_state_t state;

	assign load = ex_valid && ex_src == RES_LOAD;
	assign store = ex_valid && ex_store;

	// Data memory, async read and write on the edge
	always_ff @(posedge clk) begin
		if (store)
			dmem[ex_addr[DA:1]] <= ex_store_data;
	end

	// Same value goes to forwarding and writeback
	assign mem_fwd_data = load ? dmem[ex_addr[DA:1]] : ex_value;
	assign mem_dest = ex_wreg;
	assign mem_wen = ex_valid && ex_wen;

	// Result/writeback register
	always_ff @(posedge clk) begin
		if (reset)
			retire_valid <= 1'b0;
		else
			retire_valid <= mem_wen;
	end

	always_ff @(posedge clk) begin
		retire_reg <= mem_dest;
		retire_data <= mem_fwd_data;
	end

	// Halted once the HLT leaves this stage, sticky until reset
	always_ff @(posedge clk) begin
		if (reset)
			state <= RUN;
		else if (ex_valid && ex_halt)
			state <= HALTED;
	end

	assign hlt = (state == HALTED);

	a_one_strobe: assert property (@(posedge clk) disable iff (reset) !(load && store));

	// Nothing commits after the halt
	a_quiet_after_halt: assert property (@(posedge clk) disable iff (reset)
		hlt |-> !retire_valid);

endmodule
